/* verilog/icache_pkg.sv */
package icache_pkg;

  ////////////////////////////////////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////////////////////////////////////

  localparam int ADDR_W   = 32;
  localparam int TAG_W    = 22;
  localparam int INDEX_W  = 4;
  localparam int OFFSET_W = 4;
  localparam int WORD_W   = 32;

  // Words per line, one per offset value
  localparam int LINE_WORDS = 2 ** OFFSET_W;

  ////////////////////////////////////////////////////////////////////////
  // Fetch address
  ////////////////////////////////////////////////////////////////////////

  // Byte field is always zero for word fetches
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
    logic [1:0]          byte_off;
  } icache_fields_t;

  // Same word seen as the raw bus value or split into cache fields
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    icache_fields_t    f;
  } icache_addr_t;

endpackage

/* verilog/icache_tag_array.sv */
module icache_tag_array #(
  parameter int NUM_WAYS = 4,
  localparam int WAY_W = $clog2(NUM_WAYS)
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    lookup,
  input  icache_pkg::icache_addr_t fetch_addr,
  input  logic                    line_done,
  input  logic [WAY_W-1:0]        fill_way,
  output logic                    hit,
  output logic [WAY_W-1:0]        hit_way,
  output logic [NUM_WAYS-1:0]     valid_ways
);

  localparam int SETS = 2 ** icache_pkg::INDEX_W;

  logic [icache_pkg::TAG_W-1:0] tags [NUM_WAYS][SETS];
  logic [NUM_WAYS-1:0]          valid [SETS];

  logic [icache_pkg::TAG_W-1:0] tag_q [NUM_WAYS];
  logic [NUM_WAYS-1:0]          valid_q;
  logic [icache_pkg::INDEX_W-1:0] index;

  assign index = fetch_addr.f.index;

  // Tag storage, written once the refilled line is complete
  always_ff @(posedge clk)
  begin
    if (line_done)
      tags[fill_way][index] <= fetch_addr.f.tag;
    if (lookup)
      for (int w = 0; w < NUM_WAYS; w++)
        tag_q[w] <= tags[w][index];
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < SETS; s++)
        valid[s] <= '0;
      valid_q <= '0;
    end
    else
    begin
      if (line_done)
        valid[index][fill_way] <= 1'b1;
      if (lookup)
        valid_q <= valid[index];
    end
  end

  // Walk down so the lowest matching way wins
  always_comb
  begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--)
      if (valid_q[w] && tag_q[w] == fetch_addr.f.tag)
      begin
        hit     = 1'b1;
        hit_way = WAY_W'(w);
      end
  end

  assign valid_ways = valid_q;

endmodule

/* verilog/icache_data_array.sv */
module icache_data_array #(
  parameter int NUM_WAYS = 4,
  localparam int WAY_W = $clog2(NUM_WAYS)
) (
  input  logic                           clk,
  input  logic                           lookup,
  input  icache_pkg::icache_addr_t       fetch_addr,
  input  logic [WAY_W-1:0]               hit_way,
  input  logic [WAY_W-1:0]               fill_way,
  input  logic                           word_we,
  input  logic [icache_pkg::OFFSET_W-1:0] word_offset,
  input  logic [icache_pkg::WORD_W-1:0]  mem_data,
  output logic [icache_pkg::WORD_W-1:0]  ins
);

  localparam int SETS = 2 ** icache_pkg::INDEX_W;

  logic [icache_pkg::WORD_W-1:0] mem [NUM_WAYS][SETS][icache_pkg::LINE_WORDS];
  logic [icache_pkg::WORD_W-1:0] word_q [NUM_WAYS];

  ////////////////////////////////////////////////////////////////////////
  // Refill write and registered read
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (word_we)
      mem[fill_way][fetch_addr.f.index][word_offset] <= mem_data;
  end

  // Every way is read so the hit way can pick after the compare
  always_ff @(posedge clk)
  begin
    if (lookup)
      for (int w = 0; w < NUM_WAYS; w++)
        word_q[w] <= mem[w][fetch_addr.f.index][fetch_addr.f.offset];
  end

  assign ins = word_q[hit_way];

endmodule

/* verilog/icache_lru.sv */
module icache_lru #(
  parameter int NUM_WAYS = 4,
  localparam int WAY_W = $clog2(NUM_WAYS)
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     lookup,
  input  icache_pkg::icache_addr_t fetch_addr,
  input  logic [NUM_WAYS-1:0]      valid_ways,
  input  logic                     touch,
  input  logic [WAY_W-1:0]         touch_way,
  output logic [WAY_W-1:0]         victim
);

  localparam int SETS = 2 ** icache_pkg::INDEX_W;

  // Age 0 is the most recently used way
  logic [WAY_W-1:0] age [SETS][NUM_WAYS];
  logic [WAY_W-1:0] age_q [NUM_WAYS];
  logic [icache_pkg::INDEX_W-1:0] index;
  logic found;

  assign index = fetch_addr.f.index;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < SETS; s++)
        for (int w = 0; w < NUM_WAYS; w++)
          age[s][w] <= WAY_W'(w);
      for (int w = 0; w < NUM_WAYS; w++)
        age_q[w] <= '0;
    end
    else
    begin
      if (touch)
        for (int w = 0; w < NUM_WAYS; w++)
          if (WAY_W'(w) == touch_way)
            age[index][w] <= '0;
          else if (age[index][w] <= age[index][touch_way])
            age[index][w] <= age[index][w] + 1'b1;
      if (lookup)
        for (int w = 0; w < NUM_WAYS; w++)
          age_q[w] <= age[index][w];
    end
  end

  // Free way first, else the oldest one
  always_comb
  begin
    victim = '0;
    found  = 1'b0;
    for (int w = 0; w < NUM_WAYS; w++)
      if (!found && !valid_ways[w])
      begin
        victim = WAY_W'(w);
        found  = 1'b1;
      end
    if (!found)
      for (int w = 1; w < NUM_WAYS; w++)
        if (age_q[w] > age_q[victim])
          victim = WAY_W'(w);
  end

endmodule

/* verilog/icache_refill.sv */
module icache_refill (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            fill_start,
  input  icache_pkg::icache_addr_t        fetch_addr,
  input  logic                            mem_valid,
  output logic                            mem_req,
  output logic                            word_we,
  output logic [icache_pkg::OFFSET_W-1:0] word_offset,
  output logic                            line_done
);

  // Words received so far in this burst
  logic [icache_pkg::OFFSET_W-1:0] count;
  logic last_word;

  assign last_word = count == icache_pkg::OFFSET_W'(icache_pkg::LINE_WORDS - 1);

  ////////////////////////////////////////////////////////////////////////
  // Burst tracking
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      mem_req   <= 1'b0;
      count     <= '0;
      line_done <= 1'b0;
    end
    else
    begin
      line_done <= 1'b0;
      if (fill_start)
      begin
        mem_req <= 1'b1;
        count   <= '0;
      end
      else if (word_we)
      begin
        count <= count + 1'b1;
        if (last_word)
        begin
          mem_req   <= 1'b0;
          line_done <= 1'b1;
        end
      end
    end
  end

  // mem_req doubles as the burst-active flag
  assign word_we = mem_req && mem_valid;

  // Critical word first, then wrap around the line
  assign word_offset = fetch_addr.f.offset + count;

endmodule

/* verilog/icache_ctrl.sv */
module icache_ctrl #(
  parameter int NUM_WAYS = 4,
  localparam int WAY_W = $clog2(NUM_WAYS)
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             req,
  input  logic             hit,
  input  logic [WAY_W-1:0] hit_way,
  input  logic [WAY_W-1:0] victim,
  input  logic             line_done,
  output logic             capture,
  output logic             lookup,
  output logic             fill_start,
  output logic             touch,
  output logic             ok,
  output logic [WAY_W-1:0] fill_way,
  output logic [WAY_W-1:0] touch_way
);

  localparam logic [2:0] IDLE    = 3'd0;
  localparam logic [2:0] READ    = 3'd1;
  localparam logic [2:0] COMPARE = 3'd2;
  localparam logic [2:0] REFILL  = 3'd3;
  localparam logic [2:0] REREAD  = 3'd4;

  logic [2:0] state;
  logic [2:0] state_next;

  // ok is still high for the request just served, so skip that cycle
  assign capture = state == IDLE && req && !ok;
  assign lookup  = state == READ || state == REREAD;

  always_comb
  begin
    state_next = state;
    case (state)
      IDLE:    if (capture) state_next = READ;
      READ:    state_next = COMPARE;
      COMPARE: state_next = hit ? IDLE : REFILL;
      REFILL:  if (line_done) state_next = REREAD;
      REREAD:  state_next = COMPARE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state      <= IDLE;
      ok         <= 1'b0;
      touch      <= 1'b0;
      fill_start <= 1'b0;
    end
    else
    begin
      state      <= state_next;
      ok         <= state == COMPARE && hit;
      touch      <= state == COMPARE && hit;
      fill_start <= state == COMPARE && !hit;
    end
  end

  // Way numbers held for the lru update and the whole refill
  always_ff @(posedge clk)
  begin
    if (state == COMPARE)
    begin
      if (hit)
        touch_way <= hit_way;
      else
        fill_way <= victim;
    end
  end

endmodule

/* verilog/icache_top.sv */
module icache_top #(
  parameter int NUM_WAYS = 4
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          req,
  input  logic [icache_pkg::ADDR_W-1:0] addr,
  output logic [icache_pkg::WORD_W-1:0] ins,
  output logic                          ok,
  output logic                          mem_req,
  output logic [icache_pkg::ADDR_W-1:0] mem_addr,
  input  logic                          mem_valid,
  input  logic [icache_pkg::WORD_W-1:0] mem_data
);

  localparam int WAY_W = $clog2(NUM_WAYS);

  icache_pkg::icache_addr_t fetch_addr;

  logic capture;
  logic lookup;
  logic hit;
  logic [WAY_W-1:0] hit_way;
  logic [WAY_W-1:0] victim;
  logic [NUM_WAYS-1:0] valid_ways;
  logic fill_start;
  logic [WAY_W-1:0] fill_way;
  logic touch;
  logic [WAY_W-1:0] touch_way;
  logic word_we;
  logic [icache_pkg::OFFSET_W-1:0] word_offset;
  logic line_done;

  // Held for the whole fetch, refill included
  always_ff @(posedge clk)
  begin
    if (capture)
      fetch_addr.raw <= addr;
  end

  assign mem_addr = fetch_addr.raw;

  ////////////////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////////////////

  icache_ctrl #(.NUM_WAYS(NUM_WAYS)) u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .hit        (hit),
    .hit_way    (hit_way),
    .victim     (victim),
    .line_done  (line_done),
    .capture    (capture),
    .lookup     (lookup),
    .fill_start (fill_start),
    .touch      (touch),
    .ok         (ok),
    .fill_way   (fill_way),
    .touch_way  (touch_way)
  );

  icache_tag_array #(.NUM_WAYS(NUM_WAYS)) u_tag (
    .clk        (clk),
    .rst        (rst),
    .lookup     (lookup),
    .fetch_addr (fetch_addr),
    .line_done  (line_done),
    .fill_way   (fill_way),
    .hit        (hit),
    .hit_way    (hit_way),
    .valid_ways (valid_ways)
  );

  icache_data_array #(.NUM_WAYS(NUM_WAYS)) u_data (
    .clk         (clk),
    .lookup      (lookup),
    .fetch_addr  (fetch_addr),
    .hit_way     (hit_way),
    .fill_way    (fill_way),
    .word_we     (word_we),
    .word_offset (word_offset),
    .mem_data    (mem_data),
    .ins         (ins)
  );

  icache_lru #(.NUM_WAYS(NUM_WAYS)) u_lru (
    .clk        (clk),
    .rst        (rst),
    .lookup     (lookup),
    .fetch_addr (fetch_addr),
    .valid_ways (valid_ways),
    .touch      (touch),
    .touch_way  (touch_way),
    .victim     (victim)
  );

  icache_refill u_refill (
    .clk         (clk),
    .rst         (rst),
    .fill_start  (fill_start),
    .fetch_addr  (fetch_addr),
    .mem_valid   (mem_valid),
    .mem_req     (mem_req),
    .word_we     (word_we),
    .word_offset (word_offset),
    .line_done   (line_done)
  );

endmodule

/* dv/icache_assert.sv */
module icache_assert (
  input logic                          clk,
  input logic                          rst,
  input logic                          ok,
  input logic                          mem_req,
  input logic [icache_pkg::ADDR_W-1:0] mem_addr
);

  int fail_count = 0;

  ////////////////////////////////////////////////////////////////////////
  // CPU port
  ////////////////////////////////////////////////////////////////////////

  // ok is a single-cycle pulse
  ok_pulse: assert property (@(posedge clk) disable iff (rst) ok |=> !ok)
    else
    begin
      $error("ok stayed high for two cycles");
      fail_count++;
    end

  // No completion while a burst is open
  ok_not_in_burst: assert property (@(posedge clk) disable iff (rst) !(ok && mem_req))
    else
    begin
      $error("ok high while mem_req is high");
      fail_count++;
    end

  ////////////////////////////////////////////////////////////////////////
  // Memory port
  ////////////////////////////////////////////////////////////////////////

  mem_addr_stable: assert property (@(posedge clk) disable iff (rst)
    (mem_req && $past(mem_req)) |-> $stable(mem_addr))
    else
    begin
      $error("mem_addr changed during a burst");
      fail_count++;
    end

endmodule

/* dv/icache_tb.sv */
module icache_tb;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_WAYS   = 4;
  localparam int LINE_WORDS = 16;
  localparam int MAX_GAP    = 3;
  localparam int ROWS       = 33;
  localparam bit MISS       = 1'b0;
  localparam bit HIT        = 1'b1;

  // Memory content is the word address scrambled by this key
  localparam logic [31:0] WORD_KEY = 32'h5a3c_96e1;

  // Slowest fetch is a full burst with the largest gap before every word
  localparam int WATCHDOG_CYCLES = ROWS * (LINE_WORDS * (MAX_GAP + 1) + 16) + 100;

  logic        clk;
  logic        rst;
  logic        req;
  logic [31:0] addr;
  logic [31:0] ins;
  logic        ok;
  logic        mem_req;
  logic [31:0] mem_addr;
  logic        mem_valid;
  logic [31:0] mem_data;

  logic [31:0] rand_state = 32'h1014_bcfb;

  // Reference cache state, per set and way
  logic [21:0] ref_tag [16][NUM_WAYS];
  bit          ref_valid [16][NUM_WAYS];
  int          ref_age [16][NUM_WAYS];

  //////////////////////////////////////////////////////////////////////
  // Stimulus table, {expected hit, fetch address}
  //////////////////////////////////////////////////////////////////////

  logic [32:0] stim [ROWS] = '{
    // Cold miss in set 1, then hits in the same line
    {MISS, 32'h0000_1048},
    {HIT,  32'h0000_1048},
    {HIT,  32'h0000_1040},
    {HIT,  32'h0000_107c},
    // Five tags in set 5
    {MISS, 32'h0000_0540},
    {MISS, 32'h0000_0944},
    {MISS, 32'h0000_0d48},
    {MISS, 32'h0000_1140},
    {HIT,  32'h0000_0540},
    {MISS, 32'h0000_1540},
    {HIT,  32'h0000_0540},
    {HIT,  32'h0000_0d48},
    {HIT,  32'h0000_1140},
    {HIT,  32'h0000_1540},
    {MISS, 32'h0000_0944},
    {HIT,  32'h0000_1540},
    // Refill from offset 11, then every word of the line
    {MISS, 32'h0000_966c},
    {HIT,  32'h0000_9640}, {HIT,  32'h0000_9644}, {HIT,  32'h0000_9648}, {HIT,  32'h0000_964c},
    {HIT,  32'h0000_9650}, {HIT,  32'h0000_9654}, {HIT,  32'h0000_9658}, {HIT,  32'h0000_965c},
    {HIT,  32'h0000_9660}, {HIT,  32'h0000_9664}, {HIT,  32'h0000_9668}, {HIT,  32'h0000_966c},
    {HIT,  32'h0000_9670}, {HIT,  32'h0000_9674}, {HIT,  32'h0000_9678}, {HIT,  32'h0000_967c}
  };

  icache_top #(.NUM_WAYS(NUM_WAYS)) u_dut (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .addr      (addr),
    .ins       (ins),
    .ok        (ok),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_valid (mem_valid),
    .mem_data  (mem_data)
  );

  bind icache_top icache_assert u_assert (
    .clk      (clk),
    .rst      (rst),
    .ok       (ok),
    .mem_req  (mem_req),
    .mem_addr (mem_addr)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] memory_word(input logic [31:0] a);
    return (a >> 2) ^ WORD_KEY;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected)
    begin
      $display("ERROR t=%0t %s: got %h, expected %h", $time, name, got, expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  // Lookup, replacement and age update of the reference model
  task automatic model_fetch(input logic [31:0] a, output bit hit);
    int set;
    int way;
    int touched_age;
    set = a[9:6];
    hit = 1'b0;
    way = -1;
    for (int w = 0; w < NUM_WAYS; w++)
      if (!hit && ref_valid[set][w] && ref_tag[set][w] == a[31:10])
      begin
        hit = 1'b1;
        way = w;
      end
    if (!hit)
    begin
      for (int w = 0; w < NUM_WAYS; w++)
        if (way < 0 && !ref_valid[set][w])
          way = w;
      if (way < 0)
      begin
        way = 0;
        for (int w = 1; w < NUM_WAYS; w++)
          if (ref_age[set][w] > ref_age[set][way])
            way = w;
      end
      ref_tag[set][way] = a[31:10];
      ref_valid[set][way] = 1'b1;
    end
    touched_age = ref_age[set][way];
    for (int w = 0; w < NUM_WAYS; w++)
      if (w == way)
        ref_age[set][w] = 0;
      else if (ref_age[set][w] <= touched_age)
        ref_age[set][w]++;
  endtask

  // One fetch, with latency and data checks
  task automatic run_fetch(input logic [31:0] a, input bit expect_hit);
    int  cycles;
    int  fall_cycle;
    bit  missed;
    @(negedge clk);
    req = 1'b1;
    addr = a;
    cycles = 0;
    fall_cycle = -1;
    missed = 1'b0;
    do
    begin
      @(negedge clk);
      cycles++;
      if (mem_req && !missed)
      begin
        missed = 1'b1;
        check_value("mem_req_delay", cycles - 1, 3);
        check_value("mem_addr", mem_addr, a);
      end
      if (missed && !mem_req && fall_cycle < 0)
        fall_cycle = cycles;
    end
    while (!ok);
    check_value("mem_req_seen", missed, !expect_hit);
    if (expect_hit)
      check_value("ok_delay", cycles - 1, 2);
    else
      check_value("ok_after_burst", cycles - fall_cycle, 3);
    check_value("ins", ins, memory_word(a));
    req = 1'b0;
  endtask

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Memory model, wrapped burst with random gaps
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int gap;
    forever
    begin
      @(negedge clk);
      if (mem_req)
      begin
        for (int k = 0; k < LINE_WORDS; k++)
        begin
          rand_state = xorshift32(rand_state);
          gap = rand_state % (MAX_GAP + 1);
          repeat (gap) @(negedge clk);
          mem_valid = 1'b1;
          mem_data = memory_word({mem_addr[31:6], 4'((mem_addr[5:2] + k) % 16), 2'b00});
          @(negedge clk);
          mem_valid = 1'b0;
        end
      end
    end
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before all fetches completed");
    $display("SOME TESTS FAILED");
    $fatal(1, "Timeout");
  end

  initial
  begin
    bit model_hit;
    rst = 1'b1;
    req = 1'b0;
    addr = '0;
    mem_valid = 1'b0;
    mem_data = '0;
    for (int s = 0; s < 16; s++)
      for (int w = 0; w < NUM_WAYS; w++)
      begin
        ref_valid[s][w] = 1'b0;
        ref_age[s][w] = w;
      end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Quiet ports while idle
    repeat (10)
    begin
      @(negedge clk);
      check_value("ok", ok, 1'b0);
      check_value("mem_req", mem_req, 1'b0);
    end

    for (int i = 0; i < ROWS; i++)
    begin
      model_fetch(stim[i][31:0], model_hit);
      check_value("model_hit", model_hit, stim[i][32]);
      run_fetch(stim[i][31:0], stim[i][32]);
    end

    @(negedge clk);
    if (u_dut.u_assert.fail_count == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* list.f */
verilog/icache_pkg.sv
verilog/icache_tag_array.sv
verilog/icache_data_array.sv
verilog/icache_lru.sv
verilog/icache_refill.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
dv/icache_assert.sv
dv/icache_tb.sv

/* Bender.yml */
package:
  name: icache

sources:
  - files:
      - verilog/icache_pkg.sv
      - verilog/icache_tag_array.sv
      - verilog/icache_data_array.sv
      - verilog/icache_lru.sv
      - verilog/icache_refill.sv
      - verilog/icache_ctrl.sv
      - verilog/icache_top.sv
  - target: simulation
    files:
      - dv/icache_assert.sv
      - dv/icache_tb.sv
